// File: design/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input logic clk,
	input logic reset,
	input logic start,
	input mipsPkg::aluOp_e op,
	input mipsPkg::word_t a,
	input mipsPkg::word_t b,
	output mipsPkg::word_t result
);
	import mipsPkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else if (start) begin
			case (op)
				AluAdd: result <= a + b; // wraps mod 2^32
				AluSub: result <= a - b;
				AluAnd: result <= a & b;
				default: result <= a + b;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
	input logic clk,
	input logic reset,
	input logic instrReq,
	output logic instrAck,
	input mipsPkg::opcode_e opcode,
	input mipsPkg::funct_e funct,
	input logic shiftDone,
	output logic irLoad,
	output logic operandLoad,
	output logic aluStart,
	output logic shiftStart,
	output logic writeFromShift,
	output logic destIsRt,
	output logic regWrite,
	output mipsPkg::aluOp_e aluOp,
	output mipsPkg::shiftOp_e shiftOp
);
	import mipsPkg::*;

	state_e state;
	state_e nextState;
	logic opValid; // decoded instruction is supported
	logic decValid;
	logic decShift;
	logic decRt;
	aluOp_e decAluOp;
	shiftOp_e decShiftOp;

	always_comb begin
		decValid = 1'b1;
		decShift = 1'b0;
		decRt = 1'b0;
		decAluOp = AluAdd;
		decShiftOp = ShiftLeft;
		case (opcode)
			OpRType: begin
				case (funct)
					FnAdd: decAluOp = AluAdd;
					FnSub: decAluOp = AluSub;
					FnAnd: decAluOp = AluAnd;
					FnSll: begin
						decShift = 1'b1;
						decShiftOp = ShiftLeft;
					end
					FnSrl: begin
						decShift = 1'b1;
						decShiftOp = ShiftRightLogic;
					end
					FnSra: begin
						decShift = 1'b1;
						decShiftOp = ShiftRightArith;
					end
					default: decValid = 1'b0; // break, rte, sllv, srav, slt...
				endcase
			end
			OpAddi: decRt = 1'b1; // add of sign-extended imm into rt
			default: decValid = 1'b0;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			FetchWait: begin
				if (instrReq)
					nextState = FetchAck;
			end
			FetchAck: begin
				if (!instrReq)
					nextState = Decode;
			end
			Decode: nextState = Execute;
			Execute: begin
				if (!opValid)
					nextState = FetchWait; // unknown code, no write
				else if (writeFromShift)
					nextState = ShiftRun;
				else
					nextState = WriteBack;
			end
			ShiftRun: begin
				if (shiftDone)
					nextState = WriteBack;
			end
			WriteBack: nextState = FetchWait;
			default: nextState = FetchWait;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FetchWait;
			opValid <= 1'b0;
			writeFromShift <= 1'b0;
			destIsRt <= 1'b0;
			aluOp <= AluAdd;
			shiftOp <= ShiftLeft;
		end else begin
			state <= nextState;
			if (state == Decode) begin // held until the next decode
				opValid <= decValid;
				writeFromShift <= decShift;
				destIsRt <= decRt;
				aluOp <= decAluOp;
				shiftOp <= decShiftOp;
			end
		end
	end

	assign irLoad = (state == FetchWait) && instrReq;
	assign instrAck = (state == FetchAck);
	assign operandLoad = (state == Decode);
	assign aluStart = (state == Execute) && opValid && !writeFromShift;
	assign shiftStart = (state == Execute) && opValid && writeFromShift;
	assign regWrite = (state == WriteBack);

endmodule

`default_nettype wire

// File: design/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input logic clk,
	input logic reset,
	input mipsPkg::word_t instr,
	input logic irLoad,
	input logic operandLoad,
	input logic aluStart,
	input logic shiftStart,
	input logic writeFromShift,
	input logic destIsRt,
	input logic regWrite,
	input mipsPkg::aluOp_e aluOp,
	input mipsPkg::shiftOp_e shiftOp,
	output mipsPkg::opcode_e opcode,
	output mipsPkg::funct_e funct,
	output logic shiftDone,
	output mipsPkg::regAddr_t regWrAddr,
	output mipsPkg::word_t regWrData
);
	import mipsPkg::*;

	word_t ir;
	word_t regA;
	word_t regB;
	word_t rdDataA;
	word_t rdDataB;
	word_t immExt;
	word_t aluB;
	word_t aluResult;
	word_t shiftResult;

	always_ff @(posedge clk) begin
		if (irLoad)
			ir <= instr;
		if (operandLoad) begin
			regA <= rdDataA;
			regB <= rdDataB;
		end
	end

	assign opcode = opcode_e'(ir[OpcodeMsb:OpcodeLsb]);
	assign funct = funct_e'(ir[FunctMsb:FunctLsb]);

	assign immExt = {{(DataWidth - ImmMsb - 1){ir[ImmMsb]}}, ir[ImmMsb:ImmLsb]};
	assign aluB = destIsRt ? immExt : regB; // only addi targets rt

	assign regWrAddr = destIsRt ? ir[RtMsb:RtLsb] : ir[RdMsb:RdLsb];
	assign regWrData = writeFromShift ? shiftResult : aluResult;

	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.rdAddrA(ir[RsMsb:RsLsb]),
		.rdAddrB(ir[RtMsb:RtLsb]),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(regWrite),
		.wrAddr(regWrAddr),
		.wrData(regWrData)
	);

	aluUnit u_aluUnit (
		.clk(clk),
		.reset(reset),
		.start(aluStart),
		.op(aluOp),
		.a(regA),
		.b(aluB),
		.result(aluResult)
	);

	shiftUnit u_shiftUnit (
		.clk(clk),
		.reset(reset),
		.start(shiftStart),
		.op(shiftOp),
		.value(regB), // shifts operate on rt
		.amount(ir[ShamtMsb:ShamtLsb]),
		.result(shiftResult),
		.done(shiftDone)
	);

endmodule

`default_nettype wire

// File: design/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input logic clk,
	input logic reset,
	input logic instrReq,
	input mipsPkg::word_t instr,
	output logic instrAck,
	output logic regWrite,
	output mipsPkg::regAddr_t regWrAddr,
	output mipsPkg::word_t regWrData
);
	import mipsPkg::*;

	opcode_e opcode;
	funct_e funct;
	aluOp_e aluOp;
	shiftOp_e shiftOp;
	logic shiftDone;
	logic irLoad;
	logic operandLoad;
	logic aluStart;
	logic shiftStart;
	logic writeFromShift;
	logic destIsRt;

	controlFsm u_controlFsm (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instrAck(instrAck),
		.opcode(opcode),
		.funct(funct),
		.shiftDone(shiftDone),
		.irLoad(irLoad),
		.operandLoad(operandLoad),
		.aluStart(aluStart),
		.shiftStart(shiftStart),
		.writeFromShift(writeFromShift),
		.destIsRt(destIsRt),
		.regWrite(regWrite),
		.aluOp(aluOp),
		.shiftOp(shiftOp)
	);

	datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.irLoad(irLoad),
		.operandLoad(operandLoad),
		.aluStart(aluStart),
		.shiftStart(shiftStart),
		.writeFromShift(writeFromShift),
		.destIsRt(destIsRt),
		.regWrite(regWrite),
		.aluOp(aluOp),
		.shiftOp(shiftOp),
		.opcode(opcode),
		.funct(funct),
		.shiftDone(shiftDone),
		.regWrAddr(regWrAddr),
		.regWrData(regWrData)
	);

endmodule

`default_nettype wire

// File: design/mipsPkg.sv
`default_nettype none

package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int RegCount = 32;
	localparam int ShamtWidth = 5;

	// instruction field positions
	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 26;
	localparam int RsMsb = 25;
	localparam int RsLsb = 21;
	localparam int RtMsb = 20;
	localparam int RtLsb = 16;
	localparam int RdMsb = 15;
	localparam int RdLsb = 11;
	localparam int ShamtMsb = 10;
	localparam int ShamtLsb = 6;
	localparam int FunctMsb = 5;
	localparam int FunctLsb = 0;
	localparam int ImmMsb = 15;
	localparam int ImmLsb = 0;

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;

	typedef enum logic [5:0] {
		OpRType = 6'b000000,
		OpAddi  = 6'b001000
	} opcode_e;

	typedef enum logic [5:0] {
		FnSll = 6'b000000,
		FnSrl = 6'b000010,
		FnSra = 6'b000011,
		FnAdd = 6'b100000,
		FnSub = 6'b100010,
		FnAnd = 6'b100100
	} funct_e;

	typedef enum logic [1:0] {AluAdd, AluSub, AluAnd} aluOp_e;

	typedef enum logic [1:0] {ShiftLeft, ShiftRightLogic, ShiftRightArith} shiftOp_e;

	typedef enum logic [2:0] {
		FetchWait, FetchAck, Decode, Execute, ShiftRun, WriteBack
	} state_e;

endpackage

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input logic clk,
	input logic reset,
	input mipsPkg::regAddr_t rdAddrA,
	input mipsPkg::regAddr_t rdAddrB,
	output mipsPkg::word_t rdDataA,
	output mipsPkg::word_t rdDataB,
	input logic wrEn,
	input mipsPkg::regAddr_t wrAddr,
	input mipsPkg::word_t wrData
);
	import mipsPkg::*;

	word_t regs [RegCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RegCount; i++)
				regs[i] <= '0;
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// r0 is hard zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: design/shiftUnit.sv
`timescale 1ns/1ps
`default_nettype none

module shiftUnit (
	input logic clk,
	input logic reset,
	input logic start,
	input mipsPkg::shiftOp_e op,
	input mipsPkg::word_t value,
	input logic [mipsPkg::ShamtWidth-1:0] amount,
	output mipsPkg::word_t result,
	output logic done
);
	import mipsPkg::*;

	word_t data;
	logic [ShamtWidth-1:0] count; // shifts still to do
	logic busy;

	// last shift happens in the done cycle, so shamt n takes n cycles
	assign done = busy && (count <= ShamtWidth'(1));
	assign result = data;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy <= 1'b1;
			count <= amount;
		end else if (busy) begin
			if (count != '0)
				count <= count - 1'b1;
			if (done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			data <= value;
		end else if (busy && (count != '0)) begin
			case (op)
				ShiftLeft: data <= data << 1;
				ShiftRightLogic: data <= data >> 1;
				ShiftRightArith: data <= {data[DataWidth-1], data[DataWidth-1:1]}; // sign fill
				default: data <= data;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: mipsCore.f
design/mipsPkg.sv
design/regFile.sv
design/aluUnit.sv
design/shiftUnit.sv
design/datapath.sv
design/controlFsm.sv
design/mipsCore.sv
tests/resultChecker.sv
tests/mipsCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module mipsCoreTb \
	-f mipsCore.f -Mdir obj_dir -o simMipsCore; then
	echo "build failed"
	exit 1
fi

./obj_dir/simMipsCore > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
exit 1

// File: tests/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;

	localparam int NumRows = 33;
	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 4;
	localparam int WriteLimit = 50; // cycles allowed until the write pulse
	localparam int SettleCycles = 6; // decode and execute, then some margin
	localparam int TimeoutNs = (ResetCycles + NumRows * (40 + 5 * 4 + 32)) * ClkPeriod;

	logic clk = 1'b0;
	logic reset;
	logic instrReq;
	word_t instr;
	logic instrAck;
	logic regWrite;
	regAddr_t regWrAddr;
	word_t regWrData;

	logic rowDone;
	int testNum;
	logic expWrite;
	regAddr_t expAddr;
	word_t expData;
	int passCount;
	int failCount;
	int errorCount;

	word_t rowInstr [NumRows];
	logic rowWrite [NumRows];
	regAddr_t rowAddr [NumRows];
	word_t rowData [NumRows];
	int rowCount;
	int unsigned lcgState;

	always #(ClkPeriod / 2) clk = ~clk;

	mipsCore i_dut (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instr(instr),
		.instrAck(instrAck),
		.regWrite(regWrite),
		.regWrAddr(regWrAddr),
		.regWrData(regWrData)
	);

	resultChecker u_checker (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instrAck(instrAck),
		.regWrite(regWrite),
		.regWrAddr(regWrAddr),
		.regWrData(regWrData),
		.rowDone(rowDone),
		.testNum(testNum),
		.expWrite(expWrite),
		.expAddr(expAddr),
		.expData(expData),
		.passCount(passCount),
		.failCount(failCount),
		.errorCount(errorCount)
	);

	function automatic int unsigned randomDelay();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return (lcgState >> 16) % 6; // 0 to 5 cycles
	endfunction

	function automatic word_t rType(logic [5:0] fn, regAddr_t rd, regAddr_t rs, regAddr_t rt,
			logic [4:0] shamt);
		return {OpRType, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t iType(logic [5:0] op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic waitCycles(int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic addRow(word_t ins, logic wr, regAddr_t addr, word_t data);
		rowInstr[rowCount] = ins;
		rowWrite[rowCount] = wr;
		rowAddr[rowCount] = addr;
		rowData[rowCount] = data;
		rowCount++;
	endtask

	task automatic buildTable();
		addRow(rType(FnAdd, 5'd3, 5'd0, 5'd0, 5'd0), 1'b1, 5'd3, 32'h00000000);
		addRow(iType(OpAddi, 5'd1, 5'd0, 16'h0005), 1'b1, 5'd1, 32'h00000005);
		addRow(iType(OpAddi, 5'd2, 5'd0, 16'hFFFD), 1'b1, 5'd2, 32'hFFFFFFFD);
		addRow(iType(OpAddi, 5'd4, 5'd0, 16'h7FFF), 1'b1, 5'd4, 32'h00007FFF);
		addRow(iType(OpAddi, 5'd5, 5'd0, 16'h8000), 1'b1, 5'd5, 32'hFFFF8000);
		addRow(iType(OpAddi, 5'd6, 5'd4, 16'h0001), 1'b1, 5'd6, 32'h00008000);
		addRow(iType(OpAddi, 5'd7, 5'd1, 16'hFFFF), 1'b1, 5'd7, 32'h00000004);
		addRow(rType(FnAdd, 5'd8, 5'd1, 5'd2, 5'd0), 1'b1, 5'd8, 32'h00000002);
		addRow(rType(FnSub, 5'd9, 5'd1, 5'd4, 5'd0), 1'b1, 5'd9, 32'hFFFF8006);
		addRow(rType(FnSub, 5'd10, 5'd0, 5'd1, 5'd0), 1'b1, 5'd10, 32'hFFFFFFFB);
		addRow(rType(FnAnd, 5'd11, 5'd5, 5'd2, 5'd0), 1'b1, 5'd11, 32'hFFFF8000);
		addRow(rType(FnAnd, 5'd12, 5'd4, 5'd6, 5'd0), 1'b1, 5'd12, 32'h00000000);
		addRow(rType(FnSll, 5'd14, 5'd0, 5'd4, 5'd0), 1'b1, 5'd14, 32'h00007FFF);
		addRow(rType(FnSll, 5'd15, 5'd0, 5'd4, 5'd1), 1'b1, 5'd15, 32'h0000FFFE);
		addRow(rType(FnSll, 5'd16, 5'd0, 5'd4, 5'd17), 1'b1, 5'd16, 32'hFFFE0000);
		addRow(rType(FnSll, 5'd17, 5'd0, 5'd1, 5'd31), 1'b1, 5'd17, 32'h80000000);
		addRow(rType(FnSrl, 5'd18, 5'd0, 5'd5, 5'd1), 1'b1, 5'd18, 32'h7FFFC000);
		addRow(rType(FnSrl, 5'd19, 5'd0, 5'd5, 5'd17), 1'b1, 5'd19, 32'h00007FFF);
		addRow(rType(FnSrl, 5'd20, 5'd0, 5'd2, 5'd31), 1'b1, 5'd20, 32'h00000001);
		addRow(rType(FnSra, 5'd21, 5'd0, 5'd5, 5'd1), 1'b1, 5'd21, 32'hFFFFC000);
		addRow(rType(FnSra, 5'd22, 5'd0, 5'd5, 5'd17), 1'b1, 5'd22, 32'hFFFFFFFF);
		addRow(rType(FnSra, 5'd23, 5'd0, 5'd9, 5'd31), 1'b1, 5'd23, 32'hFFFFFFFF);
		addRow(rType(FnSra, 5'd24, 5'd0, 5'd4, 5'd1), 1'b1, 5'd24, 32'h00003FFF);
		addRow(rType(FnSra, 5'd25, 5'd0, 5'd5, 5'd0), 1'b1, 5'd25, 32'hFFFF8000);
		addRow(32'h0000000D, 1'b0, 5'd0, 32'h0); // break
		addRow(32'h42000018, 1'b0, 5'd0, 32'h0); // rte
		addRow(rType(6'b000100, 5'd27, 5'd1, 5'd4, 5'd0), 1'b0, 5'd0, 32'h0); // sllv
		addRow(rType(6'b000111, 5'd27, 5'd1, 5'd5, 5'd0), 1'b0, 5'd0, 32'h0); // srav
		addRow(rType(6'b101010, 5'd27, 5'd2, 5'd1, 5'd0), 1'b0, 5'd0, 32'h0); // slt
		addRow(iType(6'b001001, 5'd28, 5'd0, 16'h0005), 1'b0, 5'd0, 32'h0); // addiu
		addRow(rType(FnAdd, 5'd29, 5'd1, 5'd4, 5'd0), 1'b1, 5'd29, 32'h00008004);
		addRow(iType(OpAddi, 5'd0, 5'd1, 16'h0007), 1'b1, 5'd0, 32'h0000000C); // visible, not kept
		addRow(rType(FnAdd, 5'd30, 5'd0, 5'd1, 5'd0), 1'b1, 5'd30, 32'h00000005);
	endtask

	task automatic runRow(int idx);
		int waited;
		testNum = idx + 1;
		expWrite = rowWrite[idx];
		expAddr = rowAddr[idx];
		expData = rowData[idx];
		waitCycles(randomDelay());
		instr = rowInstr[idx];
		instrReq = 1'b1;
		while (!instrAck)
			@(negedge clk);
		waitCycles(randomDelay());
		instrReq = 1'b0;
		while (instrAck)
			@(negedge clk);
		if (rowWrite[idx]) begin
			waited = 0;
			while (!regWrite && waited < WriteLimit) begin
				@(negedge clk);
				waited++;
			end
			@(negedge clk); // back to fetch
		end else begin
			waitCycles(SettleCycles);
		end
		rowDone = 1'b1;
		@(negedge clk);
		rowDone = 1'b0;
		expWrite = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		rowDone = 1'b0;
		testNum = 0;
		expWrite = 1'b0;
		expAddr = '0;
		expData = '0;
		lcgState = 27;
		rowCount = 0;
		buildTable();
		waitCycles(ResetCycles);
		reset = 1'b0;
		waitCycles(2); // idle core must stay quiet
		for (int i = 0; i < rowCount; i++)
			runRow(i);
		waitCycles(2);
		$display("tests run: %0d, ok: %0d, failing: %0d, errors: %0d",
			rowCount, passCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0 && passCount == NumRows)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(TimeoutNs);
		$display("timeout: the core did not finish all tests within %0d ns", TimeoutNs);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/resultChecker.sv
`timescale 1ns/1ps
`default_nettype none

module resultChecker (
	input logic clk,
	input logic reset,
	input logic instrReq,
	input logic instrAck,
	input logic regWrite,
	input mipsPkg::regAddr_t regWrAddr,
	input mipsPkg::word_t regWrData,
	input logic rowDone,
	input int testNum,
	input logic expWrite,
	input mipsPkg::regAddr_t expAddr,
	input mipsPkg::word_t expData,
	output int passCount,
	output int failCount,
	output int errorCount
);
	import mipsPkg::*;

	int rowErrors;
	int writeCount; // writes seen in the current row
	logic prevAck;
	logic prevReq; // request as the core saw it one edge earlier

	task automatic flagError(string what);
		$display("ERROR at %0t: %s", $time, what);
		rowErrors++;
		errorCount++;
	endtask

	task automatic reportMismatch(string signalName, word_t expected, word_t actual);
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, signalName, expected, actual);
		rowErrors++;
		errorCount++;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			prevAck = 1'b0;
			prevReq = 1'b0;
			rowErrors = 0;
			writeCount = 0;
			passCount = 0;
			failCount = 0;
			errorCount = 0;
		end else begin
			if (instrAck && !prevAck && !prevReq)
				flagError("instrAck rose without a pending instrReq");
			if (!instrAck && prevAck && prevReq)
				flagError("instrAck fell while instrReq was still high");
			prevAck = instrAck;
			prevReq = instrReq;
			if (regWrite) begin
				writeCount++;
				if (!expWrite)
					flagError($sformatf("unexpected write to r%0d", regWrAddr));
				else if (writeCount > 1)
					flagError("more than one write for one instruction");
				else begin
					if (regWrAddr !== expAddr)
						reportMismatch("regWrAddr", word_t'(expAddr), word_t'(regWrAddr));
					if (regWrData !== expData)
						reportMismatch("regWrData", expData, regWrData);
				end
			end
			if (rowDone) begin
				if (expWrite && writeCount == 0)
					flagError("expected write never happened");
				if (rowErrors == 0) begin
					passCount++;
					$display("test %0d: ok", testNum);
				end else begin
					failCount++;
					$display("test %0d: FAIL with %0d errors", testNum, rowErrors);
				end
				rowErrors = 0;
				writeCount = 0;
			end
		end
	end

endmodule

`default_nettype wire
